/* src/fm_pkg.sv */
`default_nettype none

package fm_pkg;

   // array geometry
   localparam int DATA_W = 16;
   localparam int DEPTH  = 16;
   localparam int ADDR_W = $clog2(DEPTH);
   localparam int NUM_WR = 2;

   // one write port: address, data, per-bit write mask
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [DATA_W-1:0] mask;
   } wr_req_t;

   // index p is write port p, higher index wins on conflicts
   typedef wr_req_t [NUM_WR-1:0] wr_req_arr_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
   } rd_req_t;

   // addr echoed back with the word
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } rd_rsp_t;

endpackage

`default_nettype wire

/* src/fm_wr_in.sv */
`default_nettype none

module fm_wr_in
   import fm_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   // write ports, valid only
   input  logic [NUM_WR-1:0] wr_valid,
   input  wr_req_arr_t       wr_req,
   // read request channel
   input  logic              rd_valid,
   output logic              rd_ready,
   input  rd_req_t           rd_req,
   // queue space from the output side
   input  logic              rd_space,
   // registered requests
   output logic [NUM_WR-1:0] wr_stg_valid,
   output wr_req_arr_t       wr_stg,
   output logic              rd_stg_valid,
   output rd_req_t           rd_stg
);

   logic rd_fire;

   assign rd_ready = rd_space;
   assign rd_fire  = rd_valid && rd_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_stg_valid <= '0;
         rd_stg_valid <= 1'b0;
      end else begin
         wr_stg_valid <= wr_valid;
         rd_stg_valid <= rd_fire;
      end
   end

   // payload only, qualified by the valid bits above
   always_ff @(posedge clk) begin
      wr_stg <= wr_req;
      if (rd_fire) begin
         rd_stg <= rd_req;
      end
   end

   for (genvar p = 0; p < NUM_WR; p++) begin : g_wr_chk
      a_wr_addr_range: assert property (
         @(posedge clk) disable iff (rst)
         wr_valid[p] |-> (int'(wr_req[p].addr) < DEPTH)
      ) else $error("write port %0d address out of range", p);
   end

   a_rd_addr_range: assert property (
      @(posedge clk) disable iff (rst)
      rd_fire |-> (int'(rd_req.addr) < DEPTH)
   ) else $error("read address out of range");

   // request must hold until the handshake
   a_rd_req_stable: assert property (
      @(posedge clk) disable iff (rst)
      (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_req))
   ) else $error("rd_req changed while stalled");

endmodule

`default_nettype wire

/* src/fm_bit_column.sv */
`default_nettype none

module fm_bit_column
   import fm_pkg::*;
(
   input  logic                     clk,
   // one enable, address, data bit and mask bit per write port
   input  logic [NUM_WR-1:0]        we,
   input  logic [NUM_WR*ADDR_W-1:0] addr,
   input  logic [NUM_WR-1:0]        din,
   input  logic [NUM_WR-1:0]        bw,
   // bit b of every word
   output logic [DEPTH-1:0]         col
);

   logic [DEPTH-1:0] col_nxt;

   // ports applied in ascending order, so the last match is the highest port
   always_comb begin
      col_nxt = col;
      for (int p = 0; p < NUM_WR; p++) begin
         if (we[p] && bw[p]) begin
            col_nxt[addr[p*ADDR_W +: ADDR_W]] = din[p];
         end
      end
   end

   // storage flops, contents undefined after reset
   always_ff @(posedge clk) begin
      col <= col_nxt;
   end

endmodule

`default_nettype wire

/* src/fm_mem_array.sv */
`default_nettype none

module fm_mem_array
   import fm_pkg::*;
#(
   parameter int OUT_STAGES = 2
) (
   input  logic                          clk,
   input  logic [NUM_WR-1:0]             wr_stg_valid,
   input  wr_req_arr_t                   wr_stg,
   output logic [DEPTH-1:0][DATA_W-1:0]  rows
);

   logic [NUM_WR*ADDR_W-1:0]    wr_addr;
   logic [NUM_WR-1:0]           bit_din [DATA_W];
   logic [NUM_WR-1:0]           bit_bw  [DATA_W];
   logic [DEPTH-1:0]            col     [DATA_W];
   logic [DEPTH-1:0][DATA_W-1:0] rows_raw;

   // slice each port's data and mask per column
   always_comb begin
      for (int p = 0; p < NUM_WR; p++) begin
         wr_addr[p*ADDR_W +: ADDR_W] = wr_stg[p].addr;
         for (int b = 0; b < DATA_W; b++) begin
            bit_din[b][p] = wr_stg[p].data[b];
            bit_bw[b][p]  = wr_stg[p].mask[b];
         end
      end
   end

   for (genvar b = 0; b < DATA_W; b++) begin : g_col
      fm_bit_column u_col (
         .clk  (clk),
         .we   (wr_stg_valid),
         .addr (wr_addr),
         .din  (bit_din[b]),
         .bw   (bit_bw[b]),
         .col  (col[b])
      );
   end

   // columns back to words
   always_comb begin
      for (int w = 0; w < DEPTH; w++) begin
         for (int b = 0; b < DATA_W; b++) begin
            rows_raw[w][b] = col[b][w];
         end
      end
   end

   if (OUT_STAGES == 0) begin : g_no_out
      assign rows = rows_raw;
   end else begin : g_out
      logic [DEPTH-1:0][DATA_W-1:0] rows_sr [OUT_STAGES];

      always_ff @(posedge clk) begin
         rows_sr[0] <= rows_raw;
         for (int s = 1; s < OUT_STAGES; s++) begin
            rows_sr[s] <= rows_sr[s-1];
         end
      end

      assign rows = rows_sr[OUT_STAGES-1];
   end

endmodule

`default_nettype wire

/* src/fm_rd_port.sv */
`default_nettype none

module fm_rd_port
   import fm_pkg::*;
#(
   parameter int OUT_STAGES = 2,
   parameter int RSP_DEPTH  = 4
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         rd_stg_valid,
   input  rd_req_t                      rd_stg,
   input  logic [DEPTH-1:0][DATA_W-1:0] rows,
   output logic                         rd_space,
   output logic                         rsp_valid,
   input  logic                         rsp_ready,
   output rd_rsp_t                      rsp
);

   localparam int CNT_W = $clog2(RSP_DEPTH + 1);
   localparam int PTR_W = $clog2(RSP_DEPTH);

   logic              push;
   logic [ADDR_W-1:0] push_addr;
   rd_rsp_t           push_rsp;
   logic              pop;

   logic [CNT_W-1:0]  credits;
   logic [CNT_W:0]    outstanding;

   rd_rsp_t           q_mem [RSP_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  q_cnt;

   if (RSP_DEPTH < OUT_STAGES + 2) begin : g_bad_depth
      $error("RSP_DEPTH must be at least OUT_STAGES+2");
   end

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // address follows the rows through the same number of stages
   if (OUT_STAGES == 0) begin : g_no_dly
      assign push      = rd_stg_valid;
      assign push_addr = rd_stg.addr;
   end else begin : g_dly
      logic [OUT_STAGES-1:0] vld_sr;
      logic [ADDR_W-1:0]     addr_sr [OUT_STAGES];

      always_ff @(posedge clk) begin
         if (rst) begin
            vld_sr <= '0;
         end else begin
            vld_sr[0] <= rd_stg_valid;
            for (int s = 1; s < OUT_STAGES; s++) begin
               vld_sr[s] <= vld_sr[s-1];
            end
         end
      end

      always_ff @(posedge clk) begin
         addr_sr[0] <= rd_stg.addr;
         for (int s = 1; s < OUT_STAGES; s++) begin
            addr_sr[s] <= addr_sr[s-1];
         end
      end

      assign push      = vld_sr[OUT_STAGES-1];
      assign push_addr = addr_sr[OUT_STAGES-1];
   end

   assign push_rsp.addr = push_addr;
   assign push_rsp.data = rows[push_addr];

   assign pop       = rsp_valid && rsp_ready;
   assign rsp_valid = (q_cnt != '0);
   assign rsp       = q_mem[rd_ptr];

   // a read sits in rd_stg for one cycle before the counter sees it
   assign outstanding = credits + rd_stg_valid;
   assign rd_space    = (outstanding < RSP_DEPTH);

   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= '0;
      end else if (rd_stg_valid && !pop) begin
         credits <= credits + 1'b1;
      end else if (!rd_stg_valid && pop) begin
         credits <= credits - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         q_cnt  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         q_cnt <= q_cnt + push - pop;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         q_mem[wr_ptr] <= push_rsp;
      end
   end

   a_credit_bound: assert property (
      @(posedge clk) disable iff (rst)
      outstanding <= RSP_DEPTH
   ) else $error("credit count above RSP_DEPTH");

   a_no_overflow: assert property (
      @(posedge clk) disable iff (rst)
      push |-> (q_cnt < RSP_DEPTH) || pop
   ) else $error("push into full response queue");

endmodule

`default_nettype wire

/* src/fm_top.sv */
`default_nettype none

module fm_top
   import fm_pkg::*;
#(
   parameter int OUT_STAGES = 2,
   parameter int RSP_DEPTH  = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [NUM_WR-1:0] wr_valid,
   input  wr_req_arr_t       wr_req,
   input  logic              rd_valid,
   output logic              rd_ready,
   input  rd_req_t           rd_req,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output rd_rsp_t           rsp
);

   logic [NUM_WR-1:0]            wr_stg_valid;
   wr_req_arr_t                  wr_stg;
   logic                         rd_stg_valid;
   rd_req_t                      rd_stg;
   logic                         rd_space;
   logic [DEPTH-1:0][DATA_W-1:0] rows;

   fm_wr_in u_wr_in (
      .clk          (clk),
      .rst          (rst),
      .wr_valid     (wr_valid),
      .wr_req       (wr_req),
      .rd_valid     (rd_valid),
      .rd_ready     (rd_ready),
      .rd_req       (rd_req),
      .rd_space     (rd_space),
      .wr_stg_valid (wr_stg_valid),
      .wr_stg       (wr_stg),
      .rd_stg_valid (rd_stg_valid),
      .rd_stg       (rd_stg)
   );

   fm_mem_array #(
      .OUT_STAGES (OUT_STAGES)
   ) u_mem_array (
      .clk          (clk),
      .wr_stg_valid (wr_stg_valid),
      .wr_stg       (wr_stg),
      .rows         (rows)
   );

   fm_rd_port #(
      .OUT_STAGES (OUT_STAGES),
      .RSP_DEPTH  (RSP_DEPTH)
   ) u_rd_port (
      .clk          (clk),
      .rst          (rst),
      .rd_stg_valid (rd_stg_valid),
      .rd_stg       (rd_stg),
      .rows         (rows),
      .rd_space     (rd_space),
      .rsp_valid    (rsp_valid),
      .rsp_ready    (rsp_ready),
      .rsp          (rsp)
   );

endmodule

`default_nettype wire

/* testbench/fm_tb.sv */
`default_nettype none

module fm_tb
   import fm_pkg::*;
();

   localparam int RSP_DEPTH  = 4;
   localparam int TIMEOUT    = 200;
   localparam int N_RANDOM   = 600;
   // just before the rising edge, inputs and outputs have settled
   localparam int SAMPLE_DLY = 4;

   logic              clk = 1'b0;
   logic              rst;
   logic [NUM_WR-1:0] wr_valid;
   wr_req_arr_t       wr_req;
   logic              rd_valid;
   logic              rd_ready;
   rd_req_t           rd_req;
   logic              rsp_valid;
   logic              rsp_ready;
   rd_rsp_t           rsp;

   integer            seed          = 32'h749f;
   int                mismatch_cnt  = 0;
   int                timeout_cnt   = 0;
   int                other_cnt     = 0;
   int                ready_low_cnt = 0;
   logic              rd_xfer       = 1'b0;
   logic [DATA_W-1:0] model [DEPTH];
   rd_rsp_t           exp_q [$];

   fm_top dut (
      .clk       (clk),
      .rst       (rst),
      .wr_valid  (wr_valid),
      .wr_req    (wr_req),
      .rd_valid  (rd_valid),
      .rd_ready  (rd_ready),
      .rd_req    (rd_req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp)
   );

   always #5 clk = ~clk;

   task automatic check_rsp(input string name, input rd_rsp_t got, input rd_rsp_t want);
      if (got !== want) begin
         mismatch_cnt++;
         $display("MISMATCH %s: got addr %h data %h, expected addr %h data %h",
                  name, got.addr, got.data, want.addr, want.data);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      if (got !== want) begin
         mismatch_cnt++;
         $display("MISMATCH %s: got %h expected %h", name, got, want);
      end
   endtask

   // reference model, updated once per rising edge
   always @(negedge clk) begin
      rd_rsp_t want;
      #SAMPLE_DLY;
      rd_xfer = !rst && rd_valid && rd_ready;
      if (!rst) begin
         check_flag("rd_ready", rd_ready, exp_q.size() < RSP_DEPTH);
         if (!rd_ready) begin
            ready_low_cnt++;
         end
         if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
               other_cnt++;
               $display("response for addr %h arrived with no read outstanding", rsp.addr);
            end else begin
               want = exp_q.pop_front();
               check_rsp("rsp", rsp, want);
            end
         end
         // read sees the word before this edge's writes
         if (rd_xfer) begin
            want.addr = rd_req.addr;
            want.data = model[rd_req.addr];
            exp_q.push_back(want);
         end
         for (int p = 0; p < NUM_WR; p++) begin
            if (wr_valid[p]) begin
               model[wr_req[p].addr] = (model[wr_req[p].addr] & ~wr_req[p].mask)
                                     | (wr_req[p].data & wr_req[p].mask);
            end
         end
      end
   end

   task automatic set_write(input int p, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] d, input logic [DATA_W-1:0] m);
      wr_valid[p]    = 1'b1;
      wr_req[p].addr = a;
      wr_req[p].data = d;
      wr_req[p].mask = m;
   endtask

   task automatic clock_writes();
      @(negedge clk);
      wr_valid = '0;
   endtask

   // returns at a falling edge, rd_ready high unless timed out
   task automatic wait_ready();
      int n;
      n = 0;
      while (!rd_ready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!rd_ready) begin
         timeout_cnt++;
         $display("timeout: rd_ready stayed low for %0d cycles", TIMEOUT);
      end
   endtask

   task automatic issue_read(input logic [ADDR_W-1:0] a);
      wait_ready();
      rd_valid    = rd_ready;
      rd_req.addr = a;
      @(negedge clk);
      rd_valid = 1'b0;
      wr_valid = '0;
   endtask

   initial begin
      int n;
      rst       = 1'b1;
      wr_valid  = '0;
      wr_req    = '0;
      rd_valid  = 1'b0;
      rd_req    = '0;
      rsp_ready = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // known contents everywhere, ports alternate
      for (int a = 0; a < DEPTH; a++) begin
         set_write(a % NUM_WR, ADDR_W'(a), DATA_W'($random(seed)), '1);
         clock_writes();
      end

      set_write(0, 4'h3, 16'ha5c3, 16'hffff);
      set_write(1, 4'h9, 16'h3c5a, 16'hffff);
      clock_writes();
      issue_read(4'h3);
      issue_read(4'h9);

      // masked
      set_write(0, 4'h3, 16'h0000, 16'h00ff);
      set_write(1, 4'h9, 16'hffff, 16'hf0f0);
      clock_writes();
      issue_read(4'h3);
      issue_read(4'h9);

      // same word from both ports, masks overlap in 0x00f0
      set_write(0, 4'h6, 16'haaaa, 16'h0ff0);
      set_write(1, 4'h6, 16'h5555, 16'h00ff);
      clock_writes();
      issue_read(4'h6);

      // read together with a write to the same word, then once more
      wait_ready();
      set_write(0, 4'hc, 16'hbeef, 16'hffff);
      issue_read(4'hc);
      issue_read(4'hc);

      for (int i = 0; i < N_RANDOM; i++) begin
         @(negedge clk);
         wr_valid = '0;
         for (int p = 0; p < NUM_WR; p++) begin
            if (1'($random(seed))) begin
               set_write(p, ADDR_W'($random(seed)), DATA_W'($random(seed)),
                         DATA_W'($random(seed)));
            end
         end
         if (($random(seed) & 3) == 0) begin
            wr_req[1].addr = wr_req[0].addr;
         end
         if (!rd_valid || rd_xfer) begin
            rd_valid    = 1'($random(seed));
            rd_req.addr = ADDR_W'($random(seed));
         end
         // heavy back-pressure in the first half
         rsp_ready = ($random(seed) & 3) < ((i < N_RANDOM / 2) ? 1 : 3);
      end

      @(negedge clk);
      wr_valid  = '0;
      rsp_ready = 1'b1;
      n = 0;
      while (rd_valid && !rd_xfer && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (rd_valid && !rd_xfer) begin
         timeout_cnt++;
         $display("timeout: last read request was never accepted");
      end
      rd_valid = 1'b0;

      n = 0;
      while (exp_q.size() != 0 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) begin
         timeout_cnt++;
         $display("timeout: %0d responses never arrived", exp_q.size());
      end
      // catch a duplicated response
      repeat (8) @(negedge clk);
      if (ready_low_cnt == 0) begin
         other_cnt++;
         $display("rd_ready never dropped under back-pressure");
      end

      $display("errors: %0d mismatch, %0d timeout, %0d other",
               mismatch_cnt, timeout_cnt, other_cnt);
      if (mismatch_cnt + timeout_cnt + other_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
src/fm_pkg.sv
src/fm_wr_in.sv
src/fm_bit_column.sv
src/fm_mem_array.sv
src/fm_rd_port.sv
src/fm_top.sv
testbench/fm_tb.sv
